// File: project.f
verilog/CorePkg.sv
verilog/StageBus.sv
verilog/RegisterFile.sv
verilog/InstrDecode.sv
verilog/AluExecute.sv
verilog/ResultStage.sv
verilog/CoreTop.sv
testbench/CoreTb_asserts.sv
testbench/CoreChecker.sv
testbench/CoreTb.sv

// File: testbench/CoreTb.sv
`timescale 1ns/10ps

module CoreTb import CorePkg::*;
();
	localparam int CLK_HALF = 50;
	localparam int RESET_CYCLES = 8;

	typedef struct {
		word_t instr;
		word_t pc;
		int idle;
		logic wbEnable;
		regIdx_t wbReg;
		word_t wbData;
		logic redirectValid;
		word_t redirectTarget;
		string name;
	} testRow_t;

	logic clk = 1'b0;
	logic reset;
	logic instrValid;
	word_t instr;
	word_t pc;
	logic ready;
	logic resultValid;
	logic wbEnable;
	regIdx_t wbReg;
	word_t wbData;
	logic redirectValid;
	word_t redirectTarget;
	testRow_t rows [$];
	int errors;

	CoreTop i_dut (
		.clk(clk),
		.reset(reset),
		.instrValid(instrValid),
		.instr(instr),
		.pc(pc),
		.ready(ready),
		.resultValid(resultValid),
		.wbEnable(wbEnable),
		.wbReg(wbReg),
		.wbData(wbData),
		.redirectValid(redirectValid),
		.redirectTarget(redirectTarget)
	);

	CoreChecker i_check (
		.clk(clk),
		.reset(reset),
		.instrValid(instrValid),
		.ready(ready),
		.resultValid(resultValid),
		.wbEnable(wbEnable),
		.wbReg(wbReg),
		.wbData(wbData),
		.redirectValid(redirectValid),
		.redirectTarget(redirectTarget)
	);

	always
		#CLK_HALF clk = ~clk;

	function automatic word_t encodeI(opcode_t op, int rs, int rt, logic [15:0] imm);
		return {op, 5'(rs), 5'(rt), imm};
	endfunction

	function automatic word_t encodeR(int rs, int rt, int rd, int shamt, logic [5:0] funct);
		return {OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'(shamt), funct};
	endfunction

	function automatic word_t encodeJ(opcode_t op, logic [25:0] target);
		return {op, target};
	endfunction

	task automatic addRow(input word_t instrWord, input int pcVal, input int idle,
		input logic wbEn, input int regNum, input word_t wbVal, input logic redirect,
		input word_t target, input string name);
		testRow_t row;
		row.instr = instrWord;
		row.pc = pcVal;
		row.idle = idle;
		row.wbEnable = wbEn;
		row.wbReg = 5'(regNum);
		row.wbData = wbVal;
		row.redirectValid = redirect;
		row.redirectTarget = target;
		row.name = name;
		rows.push_back(row);
	endtask

	task automatic fillTable();
		// instruction, pc, idle cycles, wbEnable, wbReg, wbData, redirect, target, name
		addRow(encodeI(OP_ADDI, 0, 1, 16'h1234), 'h40, 0, 1'b1, 1, 'h1234, 1'b0, 0, "addi");
		addRow(encodeI(OP_ADDI, 0, 2, 16'hffff), 'h41, 0, 1'b1, 2, 'hffff, 1'b0, 0, "addi zext");
		addRow(encodeI(OP_ANDI, 2, 3, 16'h0f0f), 'h42, 0, 1'b1, 3, 'h0f0f, 1'b0, 0, "andi");
		addRow(encodeI(OP_ORI, 1, 4, 16'hf000), 'h43, 0, 1'b1, 4, 'hf234, 1'b0, 0, "ori");
		addRow(encodeI(OP_LUI, 0, 5, 16'habcd), 'h44, 0, 1'b1, 5, 'habcd0000, 1'b0, 0, "lui");
		addRow(encodeR(1, 2, 6, 0, FN_ADD), 'h45, 0, 1'b1, 6, 'h11233, 1'b0, 0, "add");
		addRow(encodeR(6, 1, 7, 0, FN_SUB), 'h46, 0, 1'b1, 7, 'hffff, 1'b0, 0, "sub");
		addRow(encodeR(7, 6, 8, 0, FN_AND), 'h47, 0, 1'b1, 8, 'h1233, 1'b0, 0, "and");
		addRow(encodeR(8, 5, 9, 0, FN_OR), 'h48, 0, 1'b1, 9, 'habcd1233, 1'b0, 0, "or");
		addRow(encodeR(9, 8, 10, 0, FN_SLT), 'h49, 0, 1'b1, 10, 1, 1'b0, 0, "slt true");
		addRow(encodeR(0, 10, 11, 4, FN_SLL), 'h4a, 0, 1'b1, 11, 'h10, 1'b0, 0, "sll");
		addRow(encodeR(8, 9, 12, 0, FN_SLT), 'h4b, 0, 1'b1, 12, 0, 1'b0, 0, "slt false");
		addRow(encodeI(OP_SW, 0, 9, 16'h0020), 'h4c, 0, 1'b0, 0, 0, 1'b0, 0, "sw");
		addRow(encodeI(OP_LW, 0, 13, 16'h0020), 'h4d, 1, 1'b1, 13, 'habcd1233, 1'b0, 0, "lw");
		addRow(encodeI(OP_SB, 0, 1, 16'h0030), 'h4e, 0, 1'b0, 0, 0, 1'b0, 0, "sb lane 0");
		addRow(encodeI(OP_SB, 0, 3, 16'h0031), 'h4f, 0, 1'b0, 0, 0, 1'b0, 0, "sb lane 1");
		addRow(encodeI(OP_SB, 0, 11, 16'h0032), 'h50, 0, 1'b0, 0, 0, 1'b0, 0, "sb lane 2");
		addRow(encodeI(OP_SB, 0, 2, 16'h0033), 'h51, 0, 1'b0, 0, 0, 1'b0, 0, "sb lane 3");
		addRow(encodeI(OP_LBU, 0, 14, 16'h0030), 'h52, 0, 1'b1, 14, 'h34, 1'b0, 0, "lbu lane 0");
		addRow(encodeI(OP_LBU, 0, 15, 16'h0031), 'h53, 0, 1'b1, 15, 'h0f, 1'b0, 0, "lbu lane 1");
		addRow(encodeI(OP_LBU, 0, 16, 16'h0032), 'h54, 0, 1'b1, 16, 'h10, 1'b0, 0, "lbu lane 2");
		addRow(encodeI(OP_LBU, 0, 17, 16'h0033), 'h55, 1, 1'b1, 17, 'hff, 1'b0, 0, "lbu lane 3");
		addRow(encodeI(OP_LW, 0, 18, 16'h0030), 'h56, 1, 1'b1, 18, 'hff100f34, 1'b0, 0, "lw bytes");
		addRow(encodeR(18, 14, 19, 0, FN_ADD), 'h57, 0, 1'b1, 19, 'hff100f68, 1'b0, 0, "load use");
		addRow(encodeI(OP_BEQ, 7, 2, 16'h0010), 'h58, 0, 1'b0, 0, 0, 1'b1, 'h69, "beq taken");
		addRow(encodeI(OP_BEQ, 1, 2, 16'h0005), 'h59, 0, 1'b0, 0, 0, 1'b0, 0, "beq not taken");
		addRow(encodeI(OP_BNE, 1, 2, 16'hfff0), 'h5a, 0, 1'b0, 0, 0, 1'b1, 'h4b, "bne taken");
		addRow(encodeI(OP_BNE, 12, 0, 16'h0008), 'h5b, 0, 1'b0, 0, 0, 1'b0, 0, "bne not taken");
		addRow(encodeJ(OP_JUMP, 26'h0123456), 'h5c, 0, 1'b0, 0, 0, 1'b1, 'h123456, "j");
		addRow(encodeJ(OP_JAL, 26'h0000200), 'h5d, 0, 1'b1, 31, 'h5e, 1'b1, 'h200, "jal");
		addRow(encodeR(31, 0, 20, 0, FN_ADD), 'h5e, 0, 1'b1, 20, 'h5e, 1'b0, 0, "link forward");
		addRow(encodeI(6'h11, 1, 2, 16'h1234), 'h5f, 0, 1'b0, 0, 0, 1'b0, 0, "unknown op");
		addRow(encodeI(OP_ADDI, 0, 0, 16'h0055), 'h60, 0, 1'b1, 0, 'h55, 1'b0, 0, "write r0");
		addRow(encodeR(0, 1, 21, 0, FN_ADD), 'h61, 2, 1'b1, 21, 'h1234, 1'b0, 0, "r0 forward");
		addRow(encodeR(0, 7, 22, 0, FN_ADD), 'h62, 0, 1'b1, 22, 'hffff, 1'b0, 0, "r0 read");
	endtask

	task automatic applyRow(input testRow_t row);
		instrValid = 1'b1;
		instr = row.instr;
		pc = row.pc;
		i_check.queueExpected(row.wbEnable, row.wbReg, row.wbData, row.redirectValid,
			row.redirectTarget, row.name);
		@(negedge clk);
		instrValid = 1'b0;
		repeat (row.idle) @(negedge clk);
	endtask

	// four cycles per row covers idles and drain, plus reset and clear
	task automatic runWatchdog();
		int limit;
		limit = rows.size() * 4 + 64;
		repeat (limit) @(posedge clk);
		$display("run timed out after %0d cycles without finishing", limit);
		$display("sim failed");
		$finish;
	endtask

	initial
	begin
		reset = 1'b1;
		instrValid = 1'b0;
		instr = '0;
		pc = '0;
		fillTable();
		fork
			runWatchdog();
		join_none
		repeat (RESET_CYCLES) @(negedge clk);
		reset = 1'b0;
		while (!ready)
			@(negedge clk);
		foreach (rows[i])
			applyRow(rows[i]);
		while (i_check.pending() != 0)
			@(negedge clk);
		// a few more cycles to catch stray results
		repeat (4) @(negedge clk);
		i_check.reportSummary(errors);
		errors += i_dut.i_decode.i_asserts.failCount;
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

// File: testbench/CoreChecker.sv
`timescale 1ns/10ps

module CoreChecker import CorePkg::*;
(
	input logic clk,
	input logic reset,
	input logic instrValid,
	input logic ready,
	input logic resultValid,
	input logic wbEnable,
	input regIdx_t wbReg,
	input word_t wbData,
	input logic redirectValid,
	input word_t redirectTarget
);
	// counted from the cycle the strobe is driven in
	localparam int LATENCY = 3;

	typedef struct packed {
		logic wbEnable;
		regIdx_t wbReg;
		word_t wbData;
		logic redirectValid;
		word_t redirectTarget;
	} result_t;

	result_t expQ [$];
	string nameQ [$];
	int strobeQ [$];
	int cycle = 0;
	int passCount = 0;
	int failCount = 0;

	task automatic queueExpected(input logic wbEn, input regIdx_t regNum, input word_t data,
		input logic redirect, input word_t target, input string name);
		result_t exp;
		exp.wbEnable = wbEn;
		exp.wbReg = regNum;
		exp.wbData = data;
		exp.redirectValid = redirect;
		exp.redirectTarget = target;
		expQ.push_back(exp);
		nameQ.push_back(name);
	endtask

	function automatic int pending();
		return expQ.size();
	endfunction

	task automatic checkResult();
		result_t exp;
		string name;
		string diff;
		int startCycle;
		if (expQ.size() == 0)
		begin
			$display("error at %0t: the core reported a result that no instruction expected",
				$time);
			failCount++;
			return;
		end
		exp = expQ.pop_front();
		name = nameQ.pop_front();
		startCycle = -1;
		if (strobeQ.size() != 0)
			startCycle = strobeQ.pop_front();
		diff = "";
		if (cycle - startCycle != LATENCY)
			diff = {diff, $sformatf(" latency %0d cycles instead of %0d;",
				cycle - startCycle, LATENCY)};
		if (wbEnable !== exp.wbEnable)
			diff = {diff, $sformatf(" wbEnable %0b expected %0b;", wbEnable, exp.wbEnable)};
		else if (exp.wbEnable && (wbReg !== exp.wbReg || wbData !== exp.wbData))
			diff = {diff, $sformatf(" writeback r%0d=%h expected r%0d=%h;",
				wbReg, wbData, exp.wbReg, exp.wbData)};
		if (redirectValid !== exp.redirectValid)
			diff = {diff, $sformatf(" redirectValid %0b expected %0b;",
				redirectValid, exp.redirectValid)};
		else if (exp.redirectValid && redirectTarget !== exp.redirectTarget)
			diff = {diff, $sformatf(" redirect to %h expected %h;",
				redirectTarget, exp.redirectTarget)};
		if (diff == "")
		begin
			passCount++;
			$display("[PASS] %s", name);
		end
		else
		begin
			failCount++;
			$display("[FAIL] %0t: %s:%s", $time, name, diff);
		end
	endtask

	task automatic reportSummary(output int errors);
		string name;
		while (nameQ.size() != 0)
		begin
			name = nameQ.pop_front();
			$display("error: test %s never produced a result", name);
			failCount++;
		end
		expQ.delete();
		$display("tests: %0d passed, %0d failed", passCount, failCount);
		errors = failCount;
	endtask

	always @(posedge clk)
	begin
		if (!reset && instrValid && ready)
			strobeQ.push_back(cycle);
		cycle++;
	end

	// result ports settle after the rising edge
	always @(negedge clk)
	begin
		if (!reset && resultValid)
			checkResult();
	end

endmodule

// File: testbench/CoreTb_asserts.sv
`timescale 1ns/10ps

module DecodeAsserts import CorePkg::*;
(
	input logic clk,
	input logic reset,
	input logic instrValid,
	input ctrl_t ctrl
);
	int failCount = 0;

	// no strobe means an all-zero control word
	ctrlIdle: assert property (@(posedge clk) disable iff (reset) !instrValid |-> ctrl == '0)
		else
		begin
			failCount++;
			$error("decode controls active without an instruction strobe");
		end

	memExclusive: assert property (@(posedge clk) disable iff (reset)
		!(ctrl.memRead && ctrl.memWrite))
		else
		begin
			failCount++;
			$error("memRead and memWrite asserted together");
		end

	jumpOrBranch: assert property (@(posedge clk) disable iff (reset)
		!((ctrl.jump || ctrl.jumpLink) && (ctrl.branchEq || ctrl.branchNe)))
		else
		begin
			failCount++;
			$error("jump and branch controls asserted together");
		end

endmodule

bind InstrDecode DecodeAsserts i_asserts (
	.clk(clk),
	.reset(reset),
	.instrValid(instrValid),
	.ctrl(ctrl)
);

// File: verilog/CoreTop.sv
`timescale 1ns/10ps

module CoreTop import CorePkg::*;
(
	input logic clk,
	input logic reset,
	input logic instrValid,
	input word_t instr,
	input word_t pc,
	output logic ready,
	output logic resultValid,
	output logic wbEnable,
	output regIdx_t wbReg,
	output word_t wbData,
	output logic redirectValid,
	output word_t redirectTarget
);
	regIdx_t rdAddrA;
	regIdx_t rdAddrB;
	word_t rdDataA;
	word_t rdDataB;
	logic wrEnable;
	regIdx_t wrAddr;
	word_t wrData;

	logic exValid;
	ctrl_t exCtrl;
	regIdx_t exDest;
	word_t exAlu;
	word_t exStore;
	word_t exPc;
	logic exTaken;
	word_t exTarget;

	DecodedOp dopBus();
	ForwardBus fwdBus();

	InstrDecode i_decode (
		.clk(clk),
		.reset(reset),
		.instrValid(instrValid),
		.instr(instr),
		.pc(pc),
		.ready(ready),
		.fwd(fwdBus.consumer),
		.dop(dopBus.source),
		.rdAddrA(rdAddrA),
		.rdAddrB(rdAddrB),
		.rdDataA(rdDataA),
		.rdDataB(rdDataB)
	);

	RegisterFile i_regFile (
		.clk(clk),
		.reset(reset),
		.rdAddrA(rdAddrA),
		.rdAddrB(rdAddrB),
		.wrEnable(wrEnable),
		.wrAddr(wrAddr),
		.wrData(wrData),
		.rdDataA(rdDataA),
		.rdDataB(rdDataB),
		.ready(ready)
	);

	AluExecute i_execute (
		.clk(clk),
		.reset(reset),
		.dop(dopBus.sink),
		.fwd(fwdBus.execute),
		.exValid(exValid),
		.exCtrl(exCtrl),
		.exDest(exDest),
		.exAlu(exAlu),
		.exStore(exStore),
		.exPc(exPc),
		.exTaken(exTaken),
		.exTarget(exTarget)
	);

	ResultStage i_result (
		.clk(clk),
		.reset(reset),
		.exValid(exValid),
		.exCtrl(exCtrl),
		.exDest(exDest),
		.exAlu(exAlu),
		.exStore(exStore),
		.exPc(exPc),
		.exTaken(exTaken),
		.exTarget(exTarget),
		.fwd(fwdBus.result),
		.resultValid(resultValid),
		.wbEnable(wbEnable),
		.wbReg(wbReg),
		.wbData(wbData),
		.redirectValid(redirectValid),
		.redirectTarget(redirectTarget),
		.wrEnable(wrEnable),
		.wrAddr(wrAddr),
		.wrData(wrData)
	);

endmodule

// File: verilog/ResultStage.sv
`timescale 1ns/10ps

module ResultStage import CorePkg::*;
(
	input logic clk,
	input logic reset,
	input logic exValid,
	input ctrl_t exCtrl,
	input regIdx_t exDest,
	input word_t exAlu,
	input word_t exStore,
	input word_t exPc,
	input logic exTaken,
	input word_t exTarget,
	ForwardBus.result fwd,
	output logic resultValid,
	output logic wbEnable,
	output regIdx_t wbReg,
	output word_t wbData,
	output logic redirectValid,
	output word_t redirectTarget,
	output logic wrEnable,
	output regIdx_t wrAddr,
	output word_t wrData
);
	word_t dataMem [MEM_WORDS];
	memAddr_t memIdx;
	logic [1:0] lane;
	word_t memWord;
	word_t loadData;
	word_t wbValue;

	assign memIdx = exAlu[7:2];
	assign lane = exAlu[1:0];
	assign memWord = dataMem[memIdx];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < MEM_WORDS; i++)
				dataMem[i] <= '0;
		end
		else if (exValid && exCtrl.memWrite)
		begin
			if (exCtrl.byteOp)
				dataMem[memIdx][{lane, 3'b000} +: 8] <= exStore[7:0];
			else
				dataMem[memIdx] <= exStore;
		end
	end

	// little-endian byte lanes
	always_comb
	begin
		if (exCtrl.byteOp)
			loadData = {24'b0, memWord[{lane, 3'b000} +: 8]};
		else
			loadData = memWord;
		if (exCtrl.memToReg)
			wbValue = loadData;
		else if (exCtrl.jumpLink)
			wbValue = exPc + 32'd1;
		else
			wbValue = exAlu;
	end

	assign wrEnable = exValid && exCtrl.regWrite;
	assign wrAddr = exDest;
	assign wrData = wbValue;

	assign fwd.resFwdValid = wrEnable;
	assign fwd.resFwdDest = exDest;
	assign fwd.resFwdData = wbValue;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			resultValid <= 1'b0;
			wbEnable <= 1'b0;
			redirectValid <= 1'b0;
		end
		else
		begin
			resultValid <= exValid;
			wbEnable <= wrEnable;
			redirectValid <= exValid && exTaken;
		end
	end

	always_ff @(posedge clk)
	begin
		wbReg <= exDest;
		wbData <= wbValue;
		redirectTarget <= exTarget;
	end

endmodule

// File: verilog/AluExecute.sv
`timescale 1ns/10ps

module AluExecute import CorePkg::*;
(
	input logic clk,
	input logic reset,
	DecodedOp.sink dop,
	ForwardBus.execute fwd,
	output logic exValid,
	output ctrl_t exCtrl,
	output regIdx_t exDest,
	output word_t exAlu,
	output word_t exStore,
	output word_t exPc,
	output logic exTaken,
	output word_t exTarget
);
	word_t aluOut;
	word_t pcNext;
	logic zero;
	logic taken;
	word_t target;

	always_comb
	begin
		case (dop.ctrl.aluOp)
			ALU_ADD: aluOut = dop.opA + dop.opB;
			ALU_AND: aluOut = dop.opA & dop.opB;
			ALU_OR: aluOut = dop.opA | dop.opB;
			ALU_SUB: aluOut = dop.opA - dop.opB;
			ALU_LUI: aluOut = dop.opB << 16;
			ALU_FUNCT:
			begin
				case (dop.funct)
					FN_ADD: aluOut = dop.opA + dop.opB;
					FN_SUB: aluOut = dop.opA - dop.opB;
					FN_AND: aluOut = dop.opA & dop.opB;
					FN_OR: aluOut = dop.opA | dop.opB;
					FN_SLT: aluOut = {31'b0, $signed(dop.opA) < $signed(dop.opB)};
					FN_SLL: aluOut = dop.opB << dop.shamt;
					default: aluOut = '0;
				endcase
			end
			default: aluOut = '0;
		endcase
	end

	// branches compare through the subtract result
	assign zero = (aluOut == '0);
	assign pcNext = dop.pc + 32'd1;

	always_comb
	begin
		taken = (dop.ctrl.branchEq && zero) || (dop.ctrl.branchNe && !zero);
		taken = taken || dop.ctrl.jump || dop.ctrl.jumpLink;
		if (dop.ctrl.jump || dop.ctrl.jumpLink)
			target = dop.imm;
		else
			target = pcNext + dop.imm;
	end

	// loads resolve a stage later
	assign fwd.exFwdValid = dop.valid && dop.ctrl.regWrite && !dop.ctrl.memRead;
	assign fwd.exFwdDest = dop.dest;
	assign fwd.exFwdData = dop.ctrl.jumpLink ? pcNext : aluOut;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			exValid <= 1'b0;
			exCtrl <= '0;
			exTaken <= 1'b0;
		end
		else
		begin
			exValid <= dop.valid;
			exCtrl <= dop.ctrl;
			exTaken <= taken;
		end
	end

	always_ff @(posedge clk)
	begin
		exDest <= dop.dest;
		exAlu <= aluOut;
		exStore <= dop.storeData;
		exPc <= dop.pc;
		exTarget <= target;
	end

endmodule

// File: verilog/InstrDecode.sv
`timescale 1ns/10ps

module InstrDecode import CorePkg::*;
(
	input logic clk,
	input logic reset,
	input logic instrValid,
	input word_t instr,
	input word_t pc,
	input logic ready,
	ForwardBus.consumer fwd,
	DecodedOp.source dop,
	output regIdx_t rdAddrA,
	output regIdx_t rdAddrB,
	input word_t rdDataA,
	input word_t rdDataB
);
	logic strobe;
	opcode_t opcode;
	regIdx_t rs;
	regIdx_t rt;
	regIdx_t rd;
	ctrl_t ctrl;
	word_t immExt;
	word_t rsVal;
	word_t rtVal;
	regIdx_t dest;

	// youngest producer wins, register 0 stays zero
	function automatic word_t fwdSelect(regIdx_t idx, word_t rfData);
		if (idx == '0)
			return '0;
		if (fwd.exFwdValid && fwd.exFwdDest == idx)
			return fwd.exFwdData;
		if (fwd.resFwdValid && fwd.resFwdDest == idx)
			return fwd.resFwdData;
		return rfData;
	endfunction

	assign strobe = instrValid && ready;
	assign opcode = instr[31:26];
	assign rs = instr[25:21];
	assign rt = instr[20:16];
	assign rd = instr[15:11];

	assign rdAddrA = rs;
	assign rdAddrB = rt;

	always_comb
	begin
		ctrl = '0;
		if (strobe)
		begin
			// regDst regWrite memToReg jump jumpLink memRead
			// memWrite branchEq branchNe aluSrc isSigned byteOp
			case (opcode)
				OP_LW: ctrl = {12'b0110_0100_0110, ALU_ADD};
				OP_LUI: ctrl = {12'b0100_0000_0110, ALU_LUI};
				OP_LBU: ctrl = {12'b0110_0100_0111, ALU_ADD};
				OP_SB: ctrl = {12'b0000_0010_0111, ALU_ADD};
				OP_SW: ctrl = {12'b0000_0010_0110, ALU_ADD};
				OP_RTYPE: ctrl = {12'b1100_0000_0000, ALU_FUNCT};
				OP_ADDI: ctrl = {12'b0100_0000_0100, ALU_ADD};
				OP_ANDI: ctrl = {12'b0100_0000_0100, ALU_AND};
				OP_BEQ: ctrl = {12'b0000_0001_0010, ALU_SUB};
				OP_BNE: ctrl = {12'b0000_0000_1010, ALU_SUB};
				OP_JAL: ctrl = {12'b0100_1000_0000, ALU_ADD};
				OP_JUMP: ctrl = {12'b0001_0000_0000, ALU_NONE};
				OP_ORI: ctrl = {12'b0100_0000_0100, ALU_OR};
				default: ctrl = '0;
			endcase
		end
	end

	// jumps carry their 26-bit target in the immediate slot
	always_comb
	begin
		if (ctrl.jump || ctrl.jumpLink)
			immExt = {6'b0, instr[25:0]};
		else if (ctrl.isSigned)
			immExt = {{16{instr[15]}}, instr[15:0]};
		else
			immExt = {16'b0, instr[15:0]};
	end

	always_comb
	begin
		rsVal = fwdSelect(rs, rdDataA);
		rtVal = fwdSelect(rt, rdDataB);
	end

	always_comb
	begin
		if (ctrl.regDst)
			dest = rd;
		else if (ctrl.jumpLink)
			dest = LINK_REG;
		else
			dest = rt;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			dop.valid <= 1'b0;
			dop.ctrl <= '0;
		end
		else
		begin
			dop.valid <= strobe;
			dop.ctrl <= ctrl;
		end
	end

	always_ff @(posedge clk)
	begin
		dop.pc <= pc;
		dop.opA <= rsVal;
		dop.opB <= ctrl.aluSrc ? immExt : rtVal;
		dop.storeData <= rtVal;
		dop.imm <= immExt;
		dop.shamt <= instr[10:6];
		dop.funct <= instr[5:0];
		dop.dest <= dest;
	end

endmodule

// File: verilog/RegisterFile.sv
`timescale 1ns/10ps

module RegisterFile import CorePkg::*;
(
	input logic clk,
	input logic reset,
	input regIdx_t rdAddrA,
	input regIdx_t rdAddrB,
	input logic wrEnable,
	input regIdx_t wrAddr,
	input word_t wrData,
	output word_t rdDataA,
	output word_t rdDataB,
	output logic ready
);
	word_t regs [32];
	resetState_e state;
	regIdx_t clearIdx;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= RS_CLEAR;
			clearIdx <= '0;
		end
		else if (state == RS_CLEAR)
		begin
			clearIdx <= clearIdx + 5'd1;
			if (clearIdx == 5'd31)
				state <= RS_RUN;
		end
	end

	// walk one register per cycle until all are zero
	always_ff @(posedge clk)
	begin
		if (state == RS_CLEAR)
			regs[clearIdx] <= '0;
		else if (wrEnable && wrAddr != '0)
			regs[wrAddr] <= wrData;
	end

	assign ready = (state == RS_RUN);

	assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
	assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

endmodule

// File: verilog/StageBus.sv
`timescale 1ns/10ps

interface DecodedOp import CorePkg::*; ();
	logic valid;
	ctrl_t ctrl;
	word_t pc;
	word_t opA;
	word_t opB;
	word_t storeData;
	word_t imm;
	logic [4:0] shamt;
	logic [5:0] funct;
	regIdx_t dest;

	modport source (output valid, ctrl, pc, opA, opB, storeData, imm, shamt, funct, dest);
	modport sink (input valid, ctrl, pc, opA, opB, storeData, imm, shamt, funct, dest);
endinterface

interface ForwardBus import CorePkg::*; ();
	// execute entry never carries load data
	logic exFwdValid;
	regIdx_t exFwdDest;
	word_t exFwdData;
	logic resFwdValid;
	regIdx_t resFwdDest;
	word_t resFwdData;

	modport execute (output exFwdValid, exFwdDest, exFwdData);
	modport result (output resFwdValid, resFwdDest, resFwdData);
	modport consumer (input exFwdValid, exFwdDest, exFwdData, resFwdValid, resFwdDest, resFwdData);
endinterface

// File: verilog/CorePkg.sv
package CorePkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] regIdx_t;
	typedef logic [5:0] opcode_t;
	typedef logic [3:0] aluOp_t;
	typedef logic [5:0] memAddr_t;

	// major opcodes
	localparam opcode_t OP_RTYPE = 6'h03;
	localparam opcode_t OP_JUMP = 6'h02;
	localparam opcode_t OP_JAL = 6'h07;
	localparam opcode_t OP_BNE = 6'h04;
	localparam opcode_t OP_BEQ = 6'h05;
	localparam opcode_t OP_ADDI = 6'h09;
	localparam opcode_t OP_ANDI = 6'h0c;
	localparam opcode_t OP_ORI = 6'h0e;
	localparam opcode_t OP_LUI = 6'h0f;
	localparam opcode_t OP_LW = 6'h12;
	localparam opcode_t OP_LBU = 6'h22;
	localparam opcode_t OP_SB = 6'h28;
	localparam opcode_t OP_SW = 6'h2b;

	localparam aluOp_t ALU_NONE = 4'h0;
	localparam aluOp_t ALU_FUNCT = 4'h2;
	localparam aluOp_t ALU_OR = 4'h3;
	localparam aluOp_t ALU_ADD = 4'h4;
	localparam aluOp_t ALU_AND = 4'h5;
	localparam aluOp_t ALU_SUB = 4'h7;
	localparam aluOp_t ALU_LUI = 4'hb;

	// r-type function field
	localparam logic [5:0] FN_SLL = 6'h00;
	localparam logic [5:0] FN_ADD = 6'h20;
	localparam logic [5:0] FN_SUB = 6'h22;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR = 6'h25;
	localparam logic [5:0] FN_SLT = 6'h2a;

	localparam regIdx_t LINK_REG = 5'd31;
	localparam int MEM_WORDS = 64;

	typedef struct packed {
		logic regDst;
		logic regWrite;
		logic memToReg;
		logic jump;
		logic jumpLink;
		logic memRead;
		logic memWrite;
		logic branchEq;
		logic branchNe;
		logic aluSrc;
		logic isSigned;
		logic byteOp;
		aluOp_t aluOp;
	} ctrl_t;

	typedef enum logic {RS_CLEAR, RS_RUN} resetState_e;

endpackage
